/* bench/mmu_axi_mem.sv */
`timescale 1ns/1ps

module mmu_axi_mem (
    input  logic                    clk,
    input  logic                    rst_n,
    input  mmu_axi_pkg::axi_ar_t    ar,
    input  logic                    arvalid,
    output logic                    arready,
    output mmu_axi_pkg::axi_r_t     r,
    output logic                    rvalid,
    input  mmu_axi_pkg::axi_aw_t    aw,
    input  logic                    awvalid,
    output logic                    awready,
    input  mmu_axi_pkg::axi_w_t     w,
    input  logic                    wvalid,
    output logic                    wready,
    output logic                    bvalid
);

    import mmu_axi_pkg::*;

    logic [31:0]    mem [0:16383];
    logic [31:0]    lfsr;
    logic [31:0]    rd_base;
    logic [7:0]     rd_len;
    logic [7:0]     rd_cnt;
    burst_kind_t    rd_burst;
    logic           rd_act;
    logic [31:0]    wr_addr;
    logic [31:0]    wr_data;
    logic [3:0]     wr_strb;
    logic           aw_done;
    logic           w_done;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    initial begin
        for (int i = 0; i < 16384; i++) begin
            mem[i] = (32'(i) << 2) ^ 32'h5a5a_0000;
        end
    end

    always @(posedge clk or negedge rst_n) begin
        logic [31:0] s;
        logic [31:0] a;
        if (!rst_n) begin
            lfsr    <= 32'h1594_ec5b;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            r       <= '0;
            rd_act  <= 1'b0;
            rd_cnt  <= '0;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            s = lfsr;
            if (arvalid && arready) begin
                rd_base  <= ar.addr;
                rd_len   <= ar.len;
                rd_burst <= ar.burst;
                rd_cnt   <= '0;
                rd_act   <= 1'b1;
                arready  <= 1'b0;
            end else begin
                arready <= !rd_act && s[0];
                s = lfsr_step(s);
            end
            // One beat at most per cycle, random gaps between beats
            rvalid <= 1'b0;
            if (rvalid && r.last) begin
                rd_act <= 1'b0;
            end else if (rd_act && rd_cnt <= rd_len) begin
                if (s[0]) begin
                    a = (rd_burst == burst_incr) ? rd_base + (32'(rd_cnt) << 2) : rd_base;
                    rvalid <= 1'b1;
                    r.data <= mem[a[15:2]];
                    r.last <= (rd_cnt == rd_len);
                    rd_cnt <= rd_cnt + 8'd1;
                end
                s = lfsr_step(s);
            end
            bvalid <= 1'b0;
            if (awvalid && awready) begin
                wr_addr <= aw.addr;
                aw_done <= 1'b1;
                awready <= 1'b0;
            end else begin
                awready <= !aw_done && s[0];
                s = lfsr_step(s);
            end
            if (wvalid && wready) begin
                wr_data <= w.data;
                wr_strb <= w.strb;
                w_done  <= 1'b1;
                wready  <= 1'b0;
            end else begin
                wready <= !w_done && s[0];
                s = lfsr_step(s);
            end
            if (aw_done && w_done) begin
                for (int b = 0; b < 4; b++) begin
                    if (wr_strb[b]) begin
                        mem[wr_addr[15:2]][8*b +: 8] <= wr_data[8*b +: 8];
                    end
                end
                bvalid  <= 1'b1;
                aw_done <= 1'b0;
                w_done  <= 1'b0;
            end
            lfsr <= s;
        end
    end

endmodule

/* bench/mmu_clock_gen.sv */
`timescale 1ns/1ps

module mmu_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reset held for three rising edges
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* bench/mmu_tb.sv */
`timescale 1ns/1ps

module mmu_tb;

    import mmu_axi_pkg::*;

    localparam int timeout_cycles = 200 * 60;

    logic           clk;
    logic           rst_n;
    logic           inst_en;
    logic [31:0]    inst_addr;
    logic           inst_ok;
    logic           inst_ok_1;
    logic           inst_ok_2;
    logic [31:0]    inst_data_1;
    logic [31:0]    inst_data_2;
    logic           data_en;
    logic [3:0]     data_wen;
    logic [31:0]    data_addr;
    logic [31:0]    data_wdata;
    logic           data_ok;
    logic [31:0]    data_data;
    axi_ar_t        ar;
    logic           arvalid;
    logic           arready;
    axi_r_t         r;
    logic           rvalid;
    logic           rready;
    axi_aw_t        aw;
    logic           awvalid;
    logic           awready;
    axi_w_t         w;
    logic           wvalid;
    logic           wready;
    logic           bvalid;
    logic           bready;

    // Reference model state
    logic [31:0]    shadow [0:16383];
    logic [25:0]    inst_line;
    logic           inst_line_ok;
    logic [25:0]    data_line;
    logic           data_line_ok;
    axi_ar_t        exp_ar_q[$];
    axi_aw_t        exp_aw_q[$];
    axi_w_t         exp_w_q[$];
    logic [31:0]    exp_inst_1;
    logic [31:0]    exp_inst_2;
    logic           exp_inst_ok2;
    logic [31:0]    exp_data;
    logic           data_is_read;
    logic           inst_pend;
    logic           data_pend;
    string          cur_test;
    logic [31:0]    lfsr;
    int             cycles;
    int             word_errs;
    int             ar_errs;
    int             aw_errs;
    int             w_errs;
    int             other_errs;

    mmu_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

    mmu_top UUT (.*);

    mmu_axi_mem u_mem (.*);

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    function automatic logic [31:0] ref_word(input logic [31:0] pa);
        return shadow[pa[15:2]];
    endfunction

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            word_errs++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_ar(input string name, input axi_ar_t exp, input axi_ar_t act);
        if (act !== exp) begin
            ar_errs++;
            $display("error %s: expected AR %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_aw(input string name, input axi_aw_t exp, input axi_aw_t act);
        if (act !== exp) begin
            aw_errs++;
            $display("error %s: expected AW %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_w(input string name, input axi_w_t exp, input axi_w_t act);
        if (act !== exp) begin
            w_errs++;
            $display("error %s: expected W %h, actual %h", name, exp, act);
        end
    endtask

    task automatic prep_fetch(input logic [31:0] vaddr);
        logic [31:0] pa;
        axi_ar_t     e;
        pa = {3'b000, vaddr[28:0]};
        if (!inst_line_ok || inst_line != pa[31:6]) begin
            e.addr  = {pa[31:6], 6'b0};
            e.len   = 8'd15;
            e.burst = burst_incr;
            exp_ar_q.push_back(e);
            inst_line    = pa[31:6];
            inst_line_ok = 1'b1;
        end
        exp_inst_1   = ref_word(pa);
        exp_inst_2   = ref_word(pa + 32'd4);
        exp_inst_ok2 = (pa[5:2] != 4'hf);
        inst_pend    = 1'b1;
    endtask

    task automatic prep_data(input logic [31:0] vaddr, input logic [3:0] wen,
                             input logic [31:0] wdata);
        logic [31:0] pa;
        axi_ar_t     ea;
        axi_aw_t     eaw;
        axi_w_t      ew;
        pa = {3'b000, vaddr[28:0]};
        data_is_read = (wen == 4'b0);
        if (!data_is_read) begin
            eaw.addr  = pa;
            eaw.len   = 8'd0;
            eaw.burst = burst_fixed;
            exp_aw_q.push_back(eaw);
            ew.data = wdata;
            ew.strb = wen;
            ew.last = 1'b1;
            exp_w_q.push_back(ew);
            for (int b = 0; b < 4; b++) begin
                if (wen[b]) shadow[pa[15:2]][8*b +: 8] = wdata[8*b +: 8];
            end
        end else if (vaddr[29]) begin
            ea.addr  = pa;
            ea.len   = 8'd0;
            ea.burst = burst_fixed;
            exp_ar_q.push_back(ea);
        end else if (!data_line_ok || data_line != pa[31:6]) begin
            ea.addr  = {pa[31:6], 6'b0};
            ea.len   = 8'd15;
            ea.burst = burst_incr;
            exp_ar_q.push_back(ea);
            data_line    = pa[31:6];
            data_line_ok = 1'b1;
        end
        exp_data  = ref_word(pa);
        data_pend = 1'b1;
    endtask

    task automatic run_fetch(input logic [31:0] vaddr);
        @(posedge clk);
        inst_en   <= 1'b1;
        inst_addr <= vaddr;
        @(negedge clk);
        while (!inst_ok) @(negedge clk);
        @(posedge clk);
        inst_en   <= 1'b0;
        inst_pend  = 1'b0;
    endtask

    task automatic run_data(input logic [31:0] vaddr, input logic [3:0] wen,
                            input logic [31:0] wdata);
        @(posedge clk);
        data_en    <= 1'b1;
        data_addr  <= vaddr;
        data_wen   <= wen;
        data_wdata <= wdata;
        @(negedge clk);
        while (!data_ok) @(negedge clk);
        @(posedge clk);
        data_en   <= 1'b0;
        data_pend  = 1'b0;
    endtask

    task automatic check_drained();
        if (exp_ar_q.size() != 0 || exp_aw_q.size() != 0 || exp_w_q.size() != 0) begin
            other_errs++;
            $display("%s: an expected AXI request was never issued", cur_test);
            exp_ar_q.delete();
            exp_aw_q.delete();
            exp_w_q.delete();
        end
    endtask

    task automatic fetch(input logic [31:0] vaddr);
        prep_fetch(vaddr);
        run_fetch(vaddr);
        check_drained();
    endtask

    task automatic data_access(input logic [31:0] vaddr, input logic [3:0] wen,
                               input logic [31:0] wdata);
        prep_data(vaddr, wen, wdata);
        run_data(vaddr, wen, wdata);
        check_drained();
    endtask

    // Data region at physical 0x8000, uncached alias through bit 29
    function automatic logic [31:0] data_vaddr(input logic uncached);
        logic [31:0] ofs;
        ofs = 32'h8000 + (rand_bits(3) << 6) + (rand_bits(4) << 2);
        return (uncached ? 32'hA000_0000 : 32'h8000_0000) | ofs;
    endfunction

    always @(negedge clk) begin
        if (rst_n) begin
            if (arvalid && arready) begin
                if (exp_ar_q.size() == 0) begin
                    other_errs++;
                    $display("%s: AR issued that no access needed, addr %h", cur_test, ar.addr);
                end else begin
                    check_ar(cur_test, exp_ar_q.pop_front(), ar);
                end
            end
            if (awvalid && awready) begin
                if (exp_aw_q.size() == 0) begin
                    other_errs++;
                    $display("%s: AW issued without a write", cur_test);
                end else begin
                    check_aw(cur_test, exp_aw_q.pop_front(), aw);
                end
            end
            if (wvalid && wready) begin
                if (exp_w_q.size() == 0) begin
                    other_errs++;
                    $display("%s: W issued without a write", cur_test);
                end else begin
                    check_w(cur_test, exp_w_q.pop_front(), w);
                end
            end
            if (inst_ok_1 !== inst_ok || (inst_ok_2 && !inst_ok)) begin
                other_errs++;
                $display("%s: inst_ok_1 or inst_ok_2 out of step with inst_ok", cur_test);
            end
            if (inst_ok) begin
                if (!inst_pend) begin
                    other_errs++;
                    $display("%s: instruction ok pulse without a fetch", cur_test);
                end else begin
                    check_word(cur_test, exp_inst_1, inst_data_1);
                    check_word(cur_test, {31'b0, exp_inst_ok2}, {31'b0, inst_ok_2});
                    if (exp_inst_ok2) check_word(cur_test, exp_inst_2, inst_data_2);
                end
            end
            if (data_ok) begin
                if (!data_pend) begin
                    other_errs++;
                    $display("%s: data ok pulse without an access", cur_test);
                end else if (data_is_read) begin
                    check_word(cur_test, exp_data, data_data);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        logic [31:0] va;
        logic [3:0]  wen;
        inst_en    = 1'b0;
        inst_addr  = '0;
        data_en    = 1'b0;
        data_wen   = '0;
        data_addr  = '0;
        data_wdata = '0;
        lfsr       = 32'h1594_ec5b;
        cycles     = 0;
        word_errs  = 0;
        ar_errs    = 0;
        aw_errs    = 0;
        w_errs     = 0;
        other_errs = 0;
        inst_pend  = 1'b0;
        data_pend  = 1'b0;
        inst_line_ok = 1'b0;
        data_line_ok = 1'b0;
        for (int i = 0; i < 16384; i++) begin
            shadow[i] = (32'(i) << 2) ^ 32'h5a5a_0000;
        end

        cur_test = "reset";
        wait (rst_n);
        repeat (5) begin
            @(negedge clk);
            if (inst_ok || inst_ok_1 || inst_ok_2 || data_ok || arvalid || awvalid || wvalid) begin
                other_errs++;
                $display("reset: an output was active with no request");
            end
            if (rready !== 1'b1 || bready !== 1'b1) begin
                other_errs++;
                $display("reset: rready or bready was not held high");
            end
        end

        // Instruction fetches kept below physical 0x8000, never written
        cur_test = "inst_fetch";
        fetch(32'h8000_103c);
        for (int i = 0; i < 40; i++) begin
            fetch(32'h8000_1000 + (rand_bits(3) << 6) + (rand_bits(4) << 2));
        end

        cur_test = "cached_read";
        data_access(32'h8000_8044, 4'b0, '0);
        data_access(32'h8000_8078, 4'b0, '0);
        for (int i = 0; i < 30; i++) begin
            data_access(data_vaddr(1'b0), 4'b0, '0);
        end

        cur_test = "uncached_read";
        for (int i = 0; i < 10; i++) begin
            data_access(data_vaddr(1'b1), 4'b0, '0);
        end

        cur_test = "write_merge";
        for (int i = 0; i < 20; i++) begin
            va  = data_vaddr(rand_bits(1) != 0);
            wen = 4'(rand_bits(4));
            if (wen == 4'b0) wen = 4'hf;
            // Line loaded first so that the write lands in the buffer
            data_access(va & 32'hDFFF_FFFF, 4'b0, '0);
            data_access(va, wen, rand_bits(32));
            data_access(va & 32'hDFFF_FFFF, 4'b0, '0);
            data_access(va | 32'h2000_0000, 4'b0, '0);
        end

        // Fresh lines on both ports so that each side misses
        cur_test = "dual_miss";
        for (int k = 0; k < 4; k++) begin
            prep_data(32'h8000_c000 + 32'(k) * 64 + 32'h14, 4'b0, '0);
            prep_fetch(32'h8000_3000 + 32'(k) * 64 + 32'h08);
            fork
                run_data(32'h8000_c000 + 32'(k) * 64 + 32'h14, 4'b0, '0);
                run_fetch(32'h8000_3000 + 32'(k) * 64 + 32'h08);
            join
            check_drained();
        end

        repeat (4) @(posedge clk);
        $display("errors: word %0d, ar %0d, aw %0d, w %0d, other %0d",
                 word_errs, ar_errs, aw_errs, w_errs, other_errs);
        if (word_errs + ar_errs + aw_errs + w_errs + other_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+hdl
hdl/mmu_addr_pkg.sv
hdl/mmu_axi_pkg.sv
hdl/mmu_inst.sv
hdl/mmu_data.sv
hdl/mmu_read_arbiter.sv
hdl/mmu_top.sv
bench/mmu_clock_gen.sv
bench/mmu_axi_mem.sv
bench/mmu_tb.sv

/* hdl/mmu_addr_pkg.sv */
`include "mmu_macros.svh"

package mmu_addr_pkg;

    localparam int line_tag_w = 32 - `MMU_LINE_OFS_W - 2;

    typedef logic [31:0]                  paddr_t;
    typedef logic [line_tag_w-1:0]        line_tag_t;
    typedef logic [`MMU_LINE_OFS_W-1:0]   word_ofs_t;

    typedef enum logic {
        acc_cached,
        acc_uncached
    } access_kind_t;

    // kseg-style mapping, top three bits dropped
    function automatic paddr_t to_paddr(input logic [31:0] vaddr);
        return {3'b000, vaddr[28:0]};
    endfunction

    function automatic access_kind_t access_kind(input logic [31:0] vaddr);
        return vaddr[`MMU_UNCACHED_BIT] ? acc_uncached : acc_cached;
    endfunction

    function automatic line_tag_t addr_tag(input paddr_t pa);
        return pa[31 -: line_tag_w];
    endfunction

    function automatic word_ofs_t addr_ofs(input paddr_t pa);
        return pa[2 +: `MMU_LINE_OFS_W];
    endfunction

    function automatic paddr_t line_base(input line_tag_t tag);
        return {tag, {(`MMU_LINE_OFS_W + 2){1'b0}}};
    endfunction

endpackage

/* hdl/mmu_axi_pkg.sv */
package mmu_axi_pkg;

    // Same values as the AXI burst field
    typedef enum logic [1:0] {
        burst_fixed = 2'b00,
        burst_incr  = 2'b01
    } burst_kind_t;

    typedef struct packed {
        logic [31:0]    addr;
        logic [7:0]     len;
        burst_kind_t    burst;
    } axi_ar_t;

    typedef struct packed {
        logic [31:0]    data;
        logic           last;
    } axi_r_t;

    typedef struct packed {
        logic [31:0]    addr;
        logic [7:0]     len;
        burst_kind_t    burst;
    } axi_aw_t;

    typedef struct packed {
        logic [31:0]    data;
        logic [3:0]     strb;
        logic           last;
    } axi_w_t;

    // 32-bit beats only
    localparam logic [2:0] axi_size_word = 3'b010;

    function automatic logic beat_last(input axi_r_t beat);
        return beat.last;
    endfunction

endpackage

/* hdl/mmu_data.sv */
`timescale 1ns/1ps

`include "mmu_macros.svh"

module mmu_data (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    data_en,
    input  logic [3:0]              data_wen,
    input  logic [31:0]             data_addr,
    input  logic [31:0]             data_wdata,
    output logic                    data_ok,
    output logic [31:0]             data_data,
    output logic                    rd_req,
    output mmu_axi_pkg::axi_ar_t    ar,
    input  logic                    rd_accept,
    input  logic                    r_beat,
    input  mmu_axi_pkg::axi_r_t     r,
    output mmu_axi_pkg::axi_aw_t    aw,
    output logic                    awvalid,
    input  logic                    awready,
    output mmu_axi_pkg::axi_w_t     w,
    output logic                    wvalid,
    input  logic                    wready,
    input  logic                    bvalid
);

    import mmu_addr_pkg::*;
    import mmu_axi_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_req,
        st_fill,
        st_write,
        st_resp
    } state_t;

    state_t         state;
    logic [31:0]    line_buf [`MMU_LINE_WORDS];
    line_tag_t      line_tag;
    logic           line_valid;
    paddr_t         req_pa;
    access_kind_t   req_kind;
    logic [3:0]     req_wen;
    logic [31:0]    req_wdata;
    logic [31:0]    resp_data;
    word_ofs_t      fill_cnt;
    logic           aw_pend;
    logic           w_pend;
    paddr_t         pa;
    logic           tag_hit;
    logic           is_write;
    logic           fill_wr;

    assign pa       = to_paddr(data_addr);
    assign tag_hit  = line_valid && (line_tag == addr_tag(pa));
    assign is_write = |data_wen;
    assign fill_wr  = (state == st_fill) && r_beat && (req_kind == acc_cached);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_idle;
            line_valid <= 1'b0;
            fill_cnt   <= '0;
            aw_pend    <= 1'b0;
            w_pend     <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (data_en) begin
                        if (is_write) begin
                            state   <= st_write;
                            aw_pend <= 1'b1;
                            w_pend  <= 1'b1;
                        end else if (access_kind(data_addr) == acc_cached && tag_hit) begin
                            state <= st_resp;
                        end else begin
                            state <= st_req;
                        end
                    end
                end
                st_req: begin
                    if (rd_accept) begin
                        state    <= st_fill;
                        fill_cnt <= '0;
                    end
                end
                st_fill: begin
                    if (r_beat) begin
                        fill_cnt <= fill_cnt + 1'b1;
                        if (beat_last(r)) begin
                            state <= st_resp;
                            if (req_kind == acc_cached) begin
                                line_valid <= 1'b1;
                            end
                        end
                    end
                end
                st_write: begin
                    if (awready) aw_pend <= 1'b0;
                    if (wready)  w_pend  <= 1'b0;
                    if (bvalid)  state   <= st_resp;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && data_en) begin
            req_pa    <= pa;
            req_kind  <= access_kind(data_addr);
            req_wen   <= data_wen;
            req_wdata <= data_wdata;
            resp_data <= line_buf[addr_ofs(pa)];
        end
        // Uncached beat or the requested word of a refill
        if (state == st_fill && r_beat &&
            (req_kind == acc_uncached || fill_cnt == addr_ofs(req_pa))) begin
            resp_data <= r.data;
        end
        if (fill_wr) begin
            line_buf[fill_cnt] <= r.data;
            if (beat_last(r)) begin
                line_tag <= addr_tag(req_pa);
            end
        end else if (state == st_idle && data_en && is_write && tag_hit) begin
            for (int b = 0; b < 4; b++) begin
                if (data_wen[b]) begin
                    line_buf[addr_ofs(pa)][8*b +: 8] <= data_wdata[8*b +: 8];
                end
            end
        end
    end

    assign rd_req   = (state == st_req);
    assign ar.addr  = (req_kind == acc_cached) ? line_base(addr_tag(req_pa)) : req_pa;
    assign ar.len   = (req_kind == acc_cached) ? `MMU_BURST_LINE : `MMU_BURST_SINGLE;
    assign ar.burst = (req_kind == acc_cached) ? burst_incr : burst_fixed;

    assign aw.addr  = req_pa;
    assign aw.len   = `MMU_BURST_SINGLE;
    assign aw.burst = burst_fixed;
    assign awvalid  = aw_pend;
    assign w.data   = req_wdata;
    assign w.strb   = req_wen;
    assign w.last   = 1'b1;
    assign wvalid   = w_pend;

    assign data_ok   = (state == st_resp);
    assign data_data = resp_data;

    aw_with_w_a: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(awvalid) |-> wvalid);

    ok_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
        data_ok |=> !data_ok);

endmodule

/* hdl/mmu_inst.sv */
`timescale 1ns/1ps

`include "mmu_macros.svh"

module mmu_inst (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    inst_en,
    input  logic [31:0]             inst_addr,
    output logic                    inst_ok,
    output logic                    inst_ok_1,
    output logic                    inst_ok_2,
    output logic [31:0]             inst_data_1,
    output logic [31:0]             inst_data_2,
    output logic                    rd_req,
    output mmu_axi_pkg::axi_ar_t    ar,
    input  logic                    rd_accept,
    input  logic                    r_beat,
    input  mmu_axi_pkg::axi_r_t     r
);

    import mmu_addr_pkg::*;
    import mmu_axi_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_fill,
        st_resp
    } state_t;

    state_t         state;
    logic [31:0]    line_buf [`MMU_LINE_WORDS];
    line_tag_t      line_tag;
    logic           line_valid;
    line_tag_t      req_tag;
    word_ofs_t      req_ofs;
    word_ofs_t      fill_cnt;
    paddr_t         pa;
    logic           hit;

    assign pa  = to_paddr(inst_addr);
    assign hit = line_valid && (line_tag == addr_tag(pa));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_idle;
            line_valid <= 1'b0;
            fill_cnt   <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (inst_en) begin
                        state <= hit ? st_resp : st_req;
                    end
                end
                st_req: begin
                    if (rd_accept) begin
                        state    <= st_fill;
                        fill_cnt <= '0;
                    end
                end
                st_fill: begin
                    if (r_beat) begin
                        fill_cnt <= fill_cnt + 1'b1;
                        if (beat_last(r)) begin
                            line_valid <= 1'b1;
                            state      <= st_resp;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && inst_en) begin
            req_tag <= addr_tag(pa);
            req_ofs <= addr_ofs(pa);
        end
        if (state == st_fill && r_beat) begin
            line_buf[fill_cnt] <= r.data;
            if (beat_last(r)) begin
                line_tag <= req_tag;
            end
        end
    end

    assign rd_req   = (state == st_req);
    assign ar.addr  = line_base(req_tag);
    assign ar.len   = `MMU_BURST_LINE;
    assign ar.burst = burst_incr;

    // Second word only while still inside the line
    assign inst_ok     = (state == st_resp);
    assign inst_ok_1   = inst_ok;
    assign inst_ok_2   = inst_ok && (req_ofs != word_ofs_t'(`MMU_LINE_WORDS - 1));
    assign inst_data_1 = line_buf[req_ofs];
    assign inst_data_2 = line_buf[word_ofs_t'(req_ofs + 1'b1)];

    ar_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
        rd_req && !rd_accept |=> rd_req && $stable(ar));

endmodule

/* hdl/mmu_macros.svh */
`ifndef MMU_MACROS_SVH
`define MMU_MACROS_SVH

// Line buffer geometry
`define MMU_LINE_WORDS      16
`define MMU_LINE_OFS_W      4

// AXI length field values
`define MMU_BURST_LINE      8'd15
`define MMU_BURST_SINGLE    8'd0

// Virtual address bit selecting the uncached segment
`define MMU_UNCACHED_BIT    29

`endif

/* hdl/mmu_read_arbiter.sv */
`timescale 1ns/1ps

module mmu_read_arbiter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    inst_req,
    input  mmu_axi_pkg::axi_ar_t    inst_ar,
    output logic                    inst_accept,
    output logic                    inst_beat,
    input  logic                    data_req,
    input  mmu_axi_pkg::axi_ar_t    data_ar,
    output logic                    data_accept,
    output logic                    data_beat,
    output mmu_axi_pkg::axi_ar_t    ar,
    output logic                    arvalid,
    input  logic                    arready,
    input  logic                    rvalid,
    input  mmu_axi_pkg::axi_r_t     r
);

    import mmu_axi_pkg::*;

    logic   grant_data;
    logic   busy;
    logic   sel_data;
    logic   ar_done;

    // Free: data wins; busy: hold the burst owner
    assign sel_data = busy ? grant_data : data_req;
    assign arvalid  = !busy && (sel_data ? data_req : inst_req);
    assign ar       = sel_data ? data_ar : inst_ar;
    assign ar_done  = arvalid && arready;

    assign data_accept = !busy && sel_data && arready;
    assign inst_accept = !busy && !sel_data && arready;
    assign data_beat   = busy && grant_data && rvalid;
    assign inst_beat   = busy && !grant_data && rvalid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant_data <= 1'b0;
            busy       <= 1'b0;
        end else if (!busy) begin
            if (ar_done) begin
                busy       <= 1'b1;
                grant_data <= sel_data;
            end
        end else if (rvalid && beat_last(r)) begin
            busy <= 1'b0;
        end
    end

    grant_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        busy |=> $stable(grant_data));

endmodule

/* hdl/mmu_top.sv */
`timescale 1ns/1ps

module mmu_top (
    input  logic                    clk,
    input  logic                    rst_n,
    // Instruction port
    input  logic                    inst_en,
    input  logic [31:0]             inst_addr,
    output logic                    inst_ok,
    output logic                    inst_ok_1,
    output logic                    inst_ok_2,
    output logic [31:0]             inst_data_1,
    output logic [31:0]             inst_data_2,
    // Data port
    input  logic                    data_en,
    input  logic [3:0]              data_wen,
    input  logic [31:0]             data_addr,
    input  logic [31:0]             data_wdata,
    output logic                    data_ok,
    output logic [31:0]             data_data,
    // AXI master
    output mmu_axi_pkg::axi_ar_t    ar,
    output logic                    arvalid,
    input  logic                    arready,
    input  mmu_axi_pkg::axi_r_t     r,
    input  logic                    rvalid,
    output logic                    rready,
    output mmu_axi_pkg::axi_aw_t    aw,
    output logic                    awvalid,
    input  logic                    awready,
    output mmu_axi_pkg::axi_w_t     w,
    output logic                    wvalid,
    input  logic                    wready,
    input  logic                    bvalid,
    output logic                    bready
);

    import mmu_axi_pkg::*;

    logic       inst_rd_req;
    logic       inst_accept;
    logic       inst_beat;
    axi_ar_t    inst_ar;
    logic       data_rd_req;
    logic       data_accept;
    logic       data_beat;
    axi_ar_t    data_ar;

    // R and B are never stalled
    assign rready = 1'b1;
    assign bready = 1'b1;

    mmu_inst u_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst_en     (inst_en),
        .inst_addr   (inst_addr),
        .inst_ok     (inst_ok),
        .inst_ok_1   (inst_ok_1),
        .inst_ok_2   (inst_ok_2),
        .inst_data_1 (inst_data_1),
        .inst_data_2 (inst_data_2),
        .rd_req      (inst_rd_req),
        .ar          (inst_ar),
        .rd_accept   (inst_accept),
        .r_beat      (inst_beat),
        .r           (r)
    );

    mmu_data u_data (
        .clk         (clk),
        .rst_n       (rst_n),
        .data_en     (data_en),
        .data_wen    (data_wen),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_ok     (data_ok),
        .data_data   (data_data),
        .rd_req      (data_rd_req),
        .ar          (data_ar),
        .rd_accept   (data_accept),
        .r_beat      (data_beat),
        .r           (r),
        .aw          (aw),
        .awvalid     (awvalid),
        .awready     (awready),
        .w           (w),
        .wvalid      (wvalid),
        .wready      (wready),
        .bvalid      (bvalid)
    );

    mmu_read_arbiter u_arb (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst_req    (inst_rd_req),
        .inst_ar     (inst_ar),
        .inst_accept (inst_accept),
        .inst_beat   (inst_beat),
        .data_req    (data_rd_req),
        .data_ar     (data_ar),
        .data_accept (data_accept),
        .data_beat   (data_beat),
        .ar          (ar),
        .arvalid     (arvalid),
        .arready     (arready),
        .rvalid      (rvalid),
        .r           (r)
    );

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module mmu_tb -o Vmmu_tb

out="$(./obj_dir/Vmmu_tb)"
echo "$out"

if echo "$out" | grep -qx "Done: no errors"; then
    exit 0
else
    exit 1
fi
